// File: verilog.f
rtl/lane_fifo_pkg.sv
rtl/lane_dispatch.sv
rtl/fifo_lane.sv
rtl/lane_collect.sv
rtl/lane_fifo_top.sv
dv/lane_fifo_tb.sv

// File: Makefile
# Verilator simulation of the four-lane ordered buffer

VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = lane_fifo_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# Fails unless the simulation prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/lane_fifo_tb.sv
// Self-checking testbench for the four-lane ordered buffer.
// Assumes first-word-fall-through outputs and 64 words of total storage.
`timescale 1ns/1ps
`default_nettype none

module lane_fifo_tb
    import lane_fifo_pkg::*;
();

    localparam int          TOTAL_WORDS    = NUM_LANES * LANE_DEPTH;
    localparam logic [31:0] LFSR_SEED      = 32'h6736fa7d;
    localparam int          RESET_CYCLES   = 10;
    localparam int          STALL_CYCLES   = 20;
    localparam int          RANDOM_ITEMS   = 500;
    localparam int          THRU_ITEMS     = 100;
    localparam int          BURST_ITEMS    = 300;
    localparam int          BURST_CYCLES   = 60;
    localparam int          POST_ITEMS     = 200;
    localparam int          TOTAL_ITEMS    = 2 * TOTAL_WORDS + RANDOM_ITEMS + THRU_ITEMS
                                             + BURST_ITEMS + POST_ITEMS;
    localparam int          TIMEOUT_CYCLES = 8 * TOTAL_ITEMS + 2000;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_ready;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_ready;
    logic                  all_empty;

    // Transfer bookkeeping updated by the monitor only
    int   wr_count = 0;
    int   rd_count = 0;
    logic in_taken = 1'b0;
    int   data_errors = 0;
    int   data_checks = 0;

    // Updated by the main sequence only
    int          ctl_errors;
    int          ctl_checks;
    string       test_name;
    logic [31:0] lfsr_state;

    int cycles = 0;

    lane_fifo_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .all_empty (all_empty)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // Odd multiplier keeps any 4096 consecutive items distinct
    function automatic logic [DATA_WIDTH-1:0] expected_word(input int idx);
        logic [31:0] mixed;
        mixed = 32'(idx) * 32'd2621;
        return mixed[DATA_WIDTH-1:0] ^ 12'h5a3;
    endfunction

    // In-order checker and input counter
    always @(posedge clk) begin
        if (rst) begin
            wr_count = 0;
            rd_count = 0;
            in_taken = 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                data_checks++;
                if (rd_count >= wr_count) begin
                    data_errors++;
                    $display("%s: a word left the buffer before it was written (item %0d)",
                             test_name, rd_count);
                end else if (out_data !== expected_word(rd_count)) begin
                    data_errors++;
                    $display("MISMATCH %s item %0d expected %h actual %h",
                             test_name, rd_count, expected_word(rd_count), out_data);
                end
                rd_count++;
            end
            in_taken = in_valid && in_ready;
            if (in_taken) begin
                wr_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles, during test %s",
                     TIMEOUT_CYCLES, test_name);
            $display("Summary: %0d errors in %0d checks",
                     data_errors + ctl_errors + 1, data_checks + ctl_checks);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Called at time 0 or on a falling edge
    task automatic apply_reset();
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_idle();
        ctl_checks += 3;
        if (all_empty !== 1'b1) begin
            ctl_errors++;
            $display("MISMATCH %s all_empty expected 1 actual %b", test_name, all_empty);
        end
        if (out_valid !== 1'b0) begin
            ctl_errors++;
            $display("MISMATCH %s out_valid expected 0 actual %b", test_name, out_valid);
        end
        if (in_ready !== 1'b1) begin
            ctl_errors++;
            $display("MISMATCH %s in_ready expected 1 actual %b", test_name, in_ready);
        end
    endtask

    // Writes with the output stalled until the buffer refuses a word
    task automatic fill_buffer(output int accepted);
        int start;
        start = wr_count;
        out_ready = 1'b0;
        in_valid = 1'b1;
        in_data = expected_word(wr_count);
        @(negedge clk);
        while (in_ready) begin
            in_data = expected_word(wr_count);
            @(negedge clk);
        end
        in_valid = 1'b0;
        accepted = wr_count - start;
    endtask

    task automatic drain_all();
        in_valid = 1'b0;
        out_ready = 1'b1;
        while (rd_count < wr_count) begin
            @(negedge clk);
        end
    endtask

    // Random valid and ready with a pending input word held until taken
    task automatic random_traffic(input int items, input int cycle_cap);
        int target;
        int n;
        target = wr_count + items;
        n = 0;
        while (rd_count < target && n < cycle_cap) begin
            if (!in_valid || in_taken) begin
                if (wr_count < target) begin
                    in_valid = random_bit();
                end else begin
                    in_valid = 1'b0;
                end
            end
            in_data = expected_word(wr_count);
            out_ready = random_bit();
            @(negedge clk);
            n++;
        end
        in_valid = 1'b0;
        out_ready = 1'b0;
    endtask

    initial begin
        int accepted;
        int start_wr;
        int start_rd;

        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        lfsr_state = LFSR_SEED;
        ctl_errors = 0;
        ctl_checks = 0;

        test_name = "reset";
        apply_reset();
        @(negedge clk);
        check_idle();

        test_name = "fill";
        fill_buffer(accepted);
        ctl_checks++;
        if (accepted != TOTAL_WORDS) begin
            ctl_errors++;
            $display("MISMATCH %s accepted words expected %0d actual %0d",
                     test_name, TOTAL_WORDS, accepted);
        end
        for (int i = 0; i < STALL_CYCLES; i++) begin
            @(negedge clk);
            ctl_checks += 2;
            if (in_ready !== 1'b0) begin
                ctl_errors++;
                $display("MISMATCH %s in_ready expected 0 actual %b", test_name, in_ready);
            end
            if (all_empty !== 1'b0) begin
                ctl_errors++;
                $display("MISMATCH %s all_empty expected 0 actual %b", test_name, all_empty);
            end
        end

        test_name = "drain";
        drain_all();
        ctl_checks++;
        if (rd_count != TOTAL_WORDS) begin
            ctl_errors++;
            $display("MISMATCH %s words read expected %0d actual %0d",
                     test_name, TOTAL_WORDS, rd_count);
        end
        check_idle();
        out_ready = 1'b0;

        test_name = "random";
        start_rd = rd_count;
        random_traffic(RANDOM_ITEMS, 8 * RANDOM_ITEMS);
        ctl_checks++;
        if (rd_count - start_rd != RANDOM_ITEMS) begin
            ctl_errors++;
            $display("MISMATCH %s items delivered expected %0d actual %0d",
                     test_name, RANDOM_ITEMS, rd_count - start_rd);
        end

        // One word in and one out per cycle while full
        test_name = "throughput";
        fill_buffer(accepted);
        ctl_checks++;
        if (accepted != TOTAL_WORDS) begin
            ctl_errors++;
            $display("MISMATCH %s accepted words expected %0d actual %0d",
                     test_name, TOTAL_WORDS, accepted);
        end
        start_wr = wr_count;
        start_rd = rd_count;
        in_valid = 1'b1;
        out_ready = 1'b1;
        in_data = expected_word(wr_count);
        for (int i = 0; i < THRU_ITEMS; i++) begin
            @(negedge clk);
            ctl_checks++;
            if (!in_ready || !out_valid) begin
                ctl_errors++;
                $display("%s: transfer stalled on cycle %0d (in_ready %b out_valid %b)",
                         test_name, i, in_ready, out_valid);
            end
            in_data = expected_word(wr_count);
        end
        in_valid = 1'b0;
        ctl_checks += 2;
        if (wr_count - start_wr != THRU_ITEMS) begin
            ctl_errors++;
            $display("MISMATCH %s words in expected %0d actual %0d",
                     test_name, THRU_ITEMS, wr_count - start_wr);
        end
        if (rd_count - start_rd != THRU_ITEMS) begin
            ctl_errors++;
            $display("MISMATCH %s words out expected %0d actual %0d",
                     test_name, THRU_ITEMS, rd_count - start_rd);
        end
        drain_all();
        check_idle();
        out_ready = 1'b0;

        // Reset while words are still in flight
        test_name = "reset_mid";
        random_traffic(BURST_ITEMS, BURST_CYCLES);
        apply_reset();
        @(negedge clk);
        check_idle();
        ctl_checks++;
        if (wr_count != 0 || rd_count != 0) begin
            ctl_errors++;
            $display("%s: item numbering did not restart after reset", test_name);
        end

        test_name = "after_reset";
        random_traffic(POST_ITEMS, 8 * POST_ITEMS);
        ctl_checks++;
        if (rd_count != POST_ITEMS) begin
            ctl_errors++;
            $display("MISMATCH %s items delivered expected %0d actual %0d",
                     test_name, POST_ITEMS, rd_count);
        end
        @(negedge clk);
        check_idle();

        $display("Summary: %0d errors in %0d checks",
                 data_errors + ctl_errors, data_checks + ctl_checks);
        if (data_errors + ctl_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/lane_fifo_top.sv
// Four-lane ordered buffer holding 64 words with valid/ready on both sides.
// Input ready can combinationally follow out_ready when the buffer is full.
`timescale 1ns/1ps
`default_nettype none

module lane_fifo_top
    import lane_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,

    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    input  logic                  out_ready,

    output logic                  all_empty
);

    // Dispatcher to lanes
    logic [NUM_LANES-1:0]                 lane_wr_valid;
    logic [DATA_WIDTH-1:0]                lane_wr_data;
    logic [NUM_LANES-1:0]                 lane_wr_ready;

    // Lanes to collector
    logic [NUM_LANES-1:0]                 lane_rd_valid;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] lane_rd_data;
    logic [NUM_LANES-1:0]                 lane_rd_ready;

    lane_dispatch u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_ready      (in_ready),
        .lane_wr_valid (lane_wr_valid),
        .lane_wr_data  (lane_wr_data),
        .lane_wr_ready (lane_wr_ready)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fifo_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .wr_valid (lane_wr_valid[i]),
            .wr_data  (lane_wr_data),
            .wr_ready (lane_wr_ready[i]),
            .rd_valid (lane_rd_valid[i]),
            .rd_data  (lane_rd_data[i]),
            .rd_ready (lane_rd_ready[i])
        );
    end

    lane_collect u_collect (
        .clk           (clk),
        .rst           (rst),
        .lane_rd_valid (lane_rd_valid),
        .lane_rd_data  (lane_rd_data),
        .lane_rd_ready (lane_rd_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready),
        .all_empty     (all_empty)
    );

endmodule

`default_nettype wire

// File: rtl/lane_collect.sv
// Read side of the lane rotation. Lanes are drained in the same turn order
// as the dispatcher fills them, which keeps the words in arrival order.
`timescale 1ns/1ps
`default_nettype none

module lane_collect
    import lane_fifo_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,

    // Lane read ports
    input  logic [NUM_LANES-1:0]                  lane_rd_valid,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  lane_rd_data,
    output logic [NUM_LANES-1:0]                  lane_rd_ready,

    // Downstream side
    output logic                                  out_valid,
    output logic [DATA_WIDTH-1:0]                 out_data,
    input  logic                                  out_ready,

    // Status
    output logic                                  all_empty
);

    logic [LANE_SEL_WIDTH-1:0] rd_sel;
    logic                      out_fire;

    // Head of the lane whose turn it is
    assign out_valid = lane_rd_valid[rd_sel];
    assign out_data  = lane_rd_data[rd_sel];

    // Ready goes back to the selected lane only
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_rd_ready[i] = out_ready && (rd_sel == LANE_SEL_WIDTH'(i));
        end
    end

    assign out_fire = out_valid && out_ready;

    // Empty only when no lane holds a word
    assign all_empty = ~|lane_rd_valid;

    // Read rotation index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_sel <= '0;
        end else if (out_fire) begin
            if (rd_sel == LANE_SEL_WIDTH'(NUM_LANES - 1)) begin
                rd_sel <= '0;
            end else begin
                rd_sel <= rd_sel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fifo_lane.sv
// Single circular buffer lane, first-word-fall-through on the read side.
// A full lane accepts a write only in a cycle where its head word is also taken.
`timescale 1ns/1ps
`default_nettype none

module fifo_lane
    import lane_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Write port
    input  logic                  wr_valid,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  wr_ready,

    // Read port
    output logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_ready
);

    // Storage and pointers
    logic [DATA_WIDTH-1:0]  mem [LANE_DEPTH];
    logic [ADDR_WIDTH-1:0]  wr_ptr;
    logic [ADDR_WIDTH-1:0]  rd_ptr;
    logic [COUNT_WIDTH-1:0] count;

    // Status
    logic full;
    logic empty;

    // Accepted transfers this cycle
    logic wr_do;
    logic rd_do;

    assign full  = (count == COUNT_WIDTH'(LANE_DEPTH));
    assign empty = (count == '0);

    // Head word is always on the output while the lane holds data
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_ptr];

    // A read in the same cycle frees the slot the write needs
    assign wr_ready = !full || rd_ready;

    assign wr_do = wr_valid && wr_ready;
    assign rd_do = rd_valid && rd_ready;

    // Occupancy count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_do, rd_do})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write pointer wraps at LANE_DEPTH
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_do) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_do) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage write
    // When full, wr_ptr equals rd_ptr and the old head is read out before the edge
    always_ff @(posedge clk) begin
        if (wr_do) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/lane_dispatch.sv
// Write side of the lane rotation. Words go to lanes 0..NUM_LANES-1 in strict turn,
// so a stalled lane blocks the input even when other lanes have space.
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch
    import lane_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Upstream side
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,

    // Lane write ports
    output logic [NUM_LANES-1:0]  lane_wr_valid,
    output logic [DATA_WIDTH-1:0] lane_wr_data,
    input  logic [NUM_LANES-1:0]  lane_wr_ready
);

    logic [LANE_SEL_WIDTH-1:0] wr_sel;
    logic                      in_fire;

    // Only the selected lane sees the valid
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_wr_valid[i] = in_valid && (wr_sel == LANE_SEL_WIDTH'(i));
        end
    end

    // Data bus is shared by all lanes
    assign lane_wr_data = in_data;

    // Back-pressure comes from the lane whose turn it is
    assign in_ready = lane_wr_ready[wr_sel];

    assign in_fire = in_valid && in_ready;

    // Write rotation index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_sel <= '0;
        end else if (in_fire) begin
            if (wr_sel == LANE_SEL_WIDTH'(NUM_LANES - 1)) begin
                wr_sel <= '0;
            end else begin
                wr_sel <= wr_sel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lane_fifo_pkg.sv
// Shared sizes for the four-lane ordered buffer.
// LANE_DEPTH must stay a power of two because the lane pointers wrap freely.
`default_nettype none

package lane_fifo_pkg;

    // Payload word
    localparam int DATA_WIDTH = 12;

    // Pointer width inside one lane
    localparam int ADDR_WIDTH = 4;

    // Words per lane is always 2**ADDR_WIDTH
    localparam int LANE_DEPTH = 1 << ADDR_WIDTH;

    // One extra bit so that a full lane is distinct from an empty one
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    // Lane count and rotation index width
    localparam int NUM_LANES = 4;
    localparam int LANE_SEL_WIDTH = 2;

endpackage

`default_nettype wire
